// ==== common/ag_arch_pkg.sv ====
// x86 architecture definitions for the address generation stage.
// Register widths, operand kind and size codes, segment indices
// and the snapshot of the architectural register file.

`default_nettype none

package ag_arch_pkg;

    localparam int gpr_width = 32;
    localparam int seg_width = 16;
    localparam int mm_width = 64;
    localparam int operand_width = 64;
    localparam int imm_width = 48;
    localparam int pc_width = 32;
    localparam int num_regs = 8;
    localparam int num_segs = 6;
    localparam int seg_shift = 4;

    // general register slots used by the string instructions
    localparam int gpr_esi = 6;
    localparam int gpr_edi = 7;

    typedef enum logic [2:0] {
        kind_none   = 3'd0,
        kind_reg    = 3'd1,
        kind_seg    = 3'd2,
        kind_mmx    = 3'd3,
        kind_modrm  = 3'd4,
        kind_imm    = 3'd5,
        kind_mem    = 3'd6,
        kind_unused = 3'd7
    } operand_kind_e;

    // codes 0, 4, 6 and 7 are not listed and select nothing
    typedef enum logic [2:0] {
        size_byte  = 3'd1,
        size_word  = 3'd2,
        size_dword = 3'd3,
        size_mmx   = 3'd5
    } reg_size_e;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs = 3'd1,
        seg_ss = 3'd2,
        seg_ds = 3'd3,
        seg_fs = 3'd4,
        seg_gs = 3'd5
    } seg_index_e;

    // gpr order is EAX ECX EDX EBX ESP EBP ESI EDI
    typedef struct packed {
        logic [num_regs-1:0][gpr_width-1:0] gpr;
        logic [num_segs-1:0][seg_width-1:0] seg;
        logic [num_regs-1:0][mm_width-1:0]  mm;
    } arch_state_t;

endpackage

`default_nettype wire

// ==== common/ag_stage_pkg.sv ====
// Transfer types of the address generation stage.
// Pass-through micro-op control, the incoming request and the
// result handed to the memory stage.

`default_nettype none

package ag_stage_pkg;

    // fields the stage carries without looking at them
    typedef struct packed {
        ag_arch_pkg::reg_size_e                 size;
        logic                                   set_d_flag;
        logic                                   clear_d_flag;
        logic [2:0]                             op0_reg;
        logic [2:0]                             op1_reg;
        logic [ag_arch_pkg::imm_width-1:0]      imm;
        logic [3:0]                             alu_op;
        logic [2:0]                             flag_0;
        logic [2:0]                             flag_1;
        logic [1:0]                             stack_op;
        logic [ag_arch_pkg::pc_width-1:0]       pc;
        logic                                   branch_taken;
    } uop_ctrl_t;

    typedef struct packed {
        uop_ctrl_t                              ctrl;
        ag_arch_pkg::operand_kind_e             op0_kind;
        ag_arch_pkg::operand_kind_e             op1_kind;
        ag_arch_pkg::seg_index_e                seg_override;
        logic                                   seg_override_valid;
    } ag_request_t;

    typedef struct packed {
        uop_ctrl_t                              ctrl;
        logic [ag_arch_pkg::operand_width-1:0]  op0;
        logic [ag_arch_pkg::operand_width-1:0]  op1;
        logic                                   op0_is_address;
        logic                                   op1_is_address;
    } ag_result_t;

endpackage

`default_nettype wire

// ==== src/reg_size_selector.sv ====
// Register size selector.
// Builds the eight sized views of the general registers, or the MMX
// registers, for the size code of the current micro-op.

`timescale 1ns/1ps
`default_nettype none

module reg_size_selector (
    input  ag_arch_pkg::reg_size_e     size,
    input  ag_arch_pkg::arch_state_t   regs,
    output logic [ag_arch_pkg::num_regs-1:0][ag_arch_pkg::operand_width-1:0] views
);

    always_comb begin
        for (int i = 0; i < ag_arch_pkg::num_regs; i++) begin
            views[i] = '0;
            case (size)
                ag_arch_pkg::size_byte: begin
                    // indices 4..7 are AH CH DH BH, the high byte of regs 0..3
                    if (i < 4) begin
                        views[i][7:0] = regs.gpr[i][7:0];
                    end else begin
                        views[i][7:0] = regs.gpr[i % 4][15:8];
                    end
                end
                ag_arch_pkg::size_word: begin
                    views[i][15:0] = regs.gpr[i][15:0];
                end
                ag_arch_pkg::size_dword: begin
                    views[i][ag_arch_pkg::gpr_width-1:0] = regs.gpr[i];
                end
                ag_arch_pkg::size_mmx: begin
                    views[i] = regs.mm[i];
                end
                default: begin
                    views[i] = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== operand/string_address_unit.sv ====
// String address unit.
// Destination is ES:EDI, source is DS:ESI or the override segment,
// each formed as segment shifted left by 4 plus the offset.

`timescale 1ns/1ps
`default_nettype none

module string_address_unit (
    input  ag_arch_pkg::arch_state_t            regs,
    input  ag_arch_pkg::seg_index_e             seg_override,
    input  logic                                seg_override_valid,
    output logic [ag_arch_pkg::gpr_width-1:0]   dst_address,
    output logic [ag_arch_pkg::gpr_width-1:0]   src_address
);

    logic [ag_arch_pkg::seg_width-1:0] src_seg;

    function automatic logic [ag_arch_pkg::gpr_width-1:0] seg_base(
        input logic [ag_arch_pkg::seg_width-1:0] seg
    );
        logic [ag_arch_pkg::gpr_width-1:0] wide;
        wide = '0;
        wide[ag_arch_pkg::seg_width-1:0] = seg;
        return wide << ag_arch_pkg::seg_shift;
    endfunction

    always_comb begin
        src_seg = regs.seg[ag_arch_pkg::seg_ds];
        if (seg_override_valid) begin
            case (seg_override)
                ag_arch_pkg::seg_es, ag_arch_pkg::seg_cs, ag_arch_pkg::seg_ss,
                ag_arch_pkg::seg_ds, ag_arch_pkg::seg_fs, ag_arch_pkg::seg_gs: begin
                    src_seg = regs.seg[seg_override];
                end
                // indices 6 and 7 name no segment
                default: src_seg = '0;
            endcase
        end
    end

    // ES is never overridden for the destination
    assign dst_address = seg_base(regs.seg[ag_arch_pkg::seg_es])
                       + regs.gpr[ag_arch_pkg::gpr_edi];
    assign src_address = seg_base(src_seg) + regs.gpr[ag_arch_pkg::gpr_esi];

endmodule

`default_nettype wire

// ==== operand/operand_select.sv ====
// Operand select.
// Chooses one 64-bit operand from the register views, segment and
// MMX registers, the immediate or a string address by operand kind.

`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  ag_arch_pkg::operand_kind_e              kind,
    input  logic [2:0]                              reg_index,
    input  logic [ag_arch_pkg::num_regs-1:0][ag_arch_pkg::operand_width-1:0] views,
    input  ag_arch_pkg::arch_state_t                regs,
    input  logic [ag_arch_pkg::imm_width-1:0]       imm,
    input  logic [ag_arch_pkg::gpr_width-1:0]       mem_address,
    output logic [ag_arch_pkg::operand_width-1:0]   operand,
    output logic                                    is_address
);

    always_comb begin
        operand = '0;
        case (kind)
            ag_arch_pkg::kind_reg: begin
                operand = views[reg_index];
            end
            ag_arch_pkg::kind_seg: begin
                // only ES..GS exist, 6 and 7 read as zero
                if (int'(reg_index) < ag_arch_pkg::num_segs) begin
                    operand[ag_arch_pkg::seg_width-1:0] = regs.seg[reg_index];
                end
            end
            ag_arch_pkg::kind_mmx: begin
                operand = regs.mm[reg_index];
            end
            ag_arch_pkg::kind_imm: begin
                operand[ag_arch_pkg::imm_width-1:0] = imm;
            end
            ag_arch_pkg::kind_mem: begin
                operand[ag_arch_pkg::gpr_width-1:0] = mem_address;
            end
            // none, mod r/m and the unused code
            default: begin
                operand = '0;
            end
        endcase
    end

    // mod r/m addressing is not handled here, so only memory kind flags
    assign is_address = (kind == ag_arch_pkg::kind_mem);

endmodule

`default_nettype wire

// ==== src/pipe_stage.sv ====
// Pipeline register of the address generation stage.
// One entry with a valid/ready handshake on both sides; flush
// empties the entry and refuses new input in the same cycle.

`timescale 1ns/1ps
`default_nettype none

module pipe_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  ag_stage_pkg::ag_result_t    in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    output ag_stage_pkg::ag_result_t    out_data,
    output logic                        out_valid,
    input  logic                        out_ready
);

    // free when empty or the held item leaves this cycle
    assign in_ready = (!out_valid || out_ready) && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/address_generation_top.sv ====
// Address generation stage top.
// Forms op0 and op1 for one micro-op per cycle and registers them
// with the control fields in a flushable valid/ready stage.

`timescale 1ns/1ps
`default_nettype none

module address_generation_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  ag_stage_pkg::ag_request_t   request,
    input  logic                        request_valid,
    output logic                        request_ready,
    input  ag_arch_pkg::arch_state_t    regs,
    output ag_stage_pkg::ag_result_t    result,
    output logic                        result_valid,
    input  logic                        result_ready
);

    logic [ag_arch_pkg::num_regs-1:0][ag_arch_pkg::operand_width-1:0] views;
    logic [ag_arch_pkg::gpr_width-1:0]     dst_address;
    logic [ag_arch_pkg::gpr_width-1:0]     src_address;
    logic [ag_arch_pkg::operand_width-1:0] op0;
    logic [ag_arch_pkg::operand_width-1:0] op1;
    logic                                  op0_is_address;
    logic                                  op1_is_address;
    ag_stage_pkg::ag_result_t              stage_in;

    // one set of sized views shared by both operands
    reg_size_selector size_sel_i (
        .size  (request.ctrl.size),
        .regs  (regs),
        .views (views)
    );

    string_address_unit string_addr_i (
        .regs               (regs),
        .seg_override       (request.seg_override),
        .seg_override_valid (request.seg_override_valid),
        .dst_address        (dst_address),
        .src_address        (src_address)
    );

    // op0 addresses the destination string
    operand_select op0_select_i (
        .kind        (request.op0_kind),
        .reg_index   (request.ctrl.op0_reg),
        .views       (views),
        .regs        (regs),
        .imm         (request.ctrl.imm),
        .mem_address (dst_address),
        .operand     (op0),
        .is_address  (op0_is_address)
    );

    operand_select op1_select_i (
        .kind        (request.op1_kind),
        .reg_index   (request.ctrl.op1_reg),
        .views       (views),
        .regs        (regs),
        .imm         (request.ctrl.imm),
        .mem_address (src_address),
        .operand     (op1),
        .is_address  (op1_is_address)
    );

    assign stage_in.ctrl           = request.ctrl;
    assign stage_in.op0            = op0;
    assign stage_in.op1            = op1;
    assign stage_in.op0_is_address = op0_is_address;
    assign stage_in.op1_is_address = op1_is_address;

    pipe_stage stage_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_data   (stage_in),
        .in_valid  (request_valid),
        .in_ready  (request_ready),
        .out_data  (result),
        .out_valid (result_valid),
        .out_ready (result_ready)
    );

endmodule

`default_nettype wire

// ==== tests/address_generation_properties.sv ====
// Handshake properties of the address generation stage,
// bound to its top level.

`timescale 1ns/1ps
`default_nettype none

module address_generation_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush,
    input logic                     request_valid,
    input logic                     request_ready,
    input ag_stage_pkg::ag_result_t result,
    input logic                     result_valid,
    input logic                     result_ready
);

    // nothing is valid during reset or just after it
    reset_clears_valid: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("result_valid high during or right after reset");

    // a stalled result must not change under the consumer
    held_result_stable: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready && !flush |=> result_valid && $stable(result))
        else $error("result changed or dropped while stalled");

    accept_into_empty: assert property (@(posedge clk) disable iff (reset)
        request_valid && request_ready && !result_valid |=> result_valid)
        else $error("accepted request did not appear one cycle later");

endmodule

`default_nettype wire

// ==== tests/address_generation_tb.sv ====
// Testbench for the address generation stage.
// Random register snapshots, requests, back-pressure and flushes,
// with every result compared against a reference model.

`timescale 1ns/1ps
`default_nettype none

module address_generation_tb;

    localparam int num_results = 500;
    localparam int max_cycles  = 20000;
    localparam int wait_limit  = 64;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       flush;
    ag_stage_pkg::ag_request_t  request;
    logic                       request_valid;
    logic                       request_ready;
    ag_arch_pkg::arch_state_t   regs;
    ag_stage_pkg::ag_result_t   result;
    logic                       result_valid;
    logic                       result_ready;

    ag_stage_pkg::ag_result_t   expected_q[$];

    address_generation_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .request       (request),
        .request_valid (request_valid),
        .request_ready (request_ready),
        .regs          (regs),
        .result        (result),
        .result_valid  (result_valid),
        .result_ready  (result_ready)
    );

    bind address_generation_top address_generation_properties props_i (
        .clk, .reset, .flush, .request_valid, .request_ready,
        .result, .result_valid, .result_ready
    );

    always #20 clk = ~clk;

    function automatic logic [63:0] register_view(
        input ag_arch_pkg::arch_state_t r,
        input logic [2:0]               idx,
        input logic [2:0]               size
    );
        case (size)
            3'd1: begin
                // upper four indices are AH CH DH BH
                if (idx[2]) begin
                    return 64'(r.gpr[idx[1:0]][15:8]);
                end else begin
                    return 64'(r.gpr[idx][7:0]);
                end
            end
            3'd2: return 64'(r.gpr[idx][15:0]);
            3'd3: return 64'(r.gpr[idx]);
            3'd5: return r.mm[idx];
            default: return 64'h0;
        endcase
    endfunction

    function automatic logic [31:0] linear_address(
        input logic [15:0] seg,
        input logic [31:0] offset
    );
        return {12'h0, seg, 4'h0} + offset;
    endfunction

    function automatic logic [63:0] operand_model(
        input logic [2:0]               kind,
        input logic [2:0]               idx,
        input logic [2:0]               size,
        input ag_arch_pkg::arch_state_t r,
        input logic [47:0]              imm,
        input logic [31:0]              address
    );
        case (kind)
            3'd1: return register_view(r, idx, size);
            3'd2: return (idx < 3'd6) ? 64'(r.seg[idx]) : 64'h0;
            3'd3: return r.mm[idx];
            3'd5: return 64'(imm);
            3'd6: return 64'(address);
            default: return 64'h0;
        endcase
    endfunction

    function automatic ag_stage_pkg::ag_result_t expected_result(
        input ag_stage_pkg::ag_request_t req,
        input ag_arch_pkg::arch_state_t  r
    );
        ag_stage_pkg::ag_result_t exp;
        logic [15:0]              src_seg;
        // DS unless overridden, ES is seg 0, ESI gpr 6, EDI gpr 7
        src_seg = r.seg[3];
        if (req.seg_override_valid) begin
            src_seg = (req.seg_override < 3'd6) ? r.seg[req.seg_override] : 16'h0;
        end
        exp.ctrl = req.ctrl;
        exp.op0 = operand_model(req.op0_kind, req.ctrl.op0_reg, req.ctrl.size, r,
                                req.ctrl.imm, linear_address(r.seg[0], r.gpr[7]));
        exp.op1 = operand_model(req.op1_kind, req.ctrl.op1_reg, req.ctrl.size, r,
                                req.ctrl.imm, linear_address(src_seg, r.gpr[6]));
        exp.op0_is_address = (req.op0_kind == 3'd6);
        exp.op1_is_address = (req.op1_kind == 3'd6);
        return exp;
    endfunction

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (act === exp) else begin
            $display("** Error %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_result(input ag_stage_pkg::ag_result_t act);
        ag_stage_pkg::ag_result_t exp;
        if (expected_q.size() == 0) begin
            $display("a result came out with no accepted request outstanding");
            stop_on_error();
        end else begin
            exp = expected_q.pop_front();
            compare("ctrl", 128'(exp.ctrl), 128'(act.ctrl));
            compare("op0", 128'(exp.op0), 128'(act.op0));
            compare("op1", 128'(exp.op1), 128'(act.op1));
            compare("address_flags", 128'({exp.op0_is_address, exp.op1_is_address}),
                    128'({act.op0_is_address, act.op1_is_address}));
        end
    endtask

    // new payload and register snapshot, held until accepted
    task automatic offer_request();
        logic [127:0] req_bits;
        logic [895:0] reg_bits;
        for (int i = 0; i < 4; i++) begin
            req_bits[i*32 +: 32] = $urandom;
        end
        for (int i = 0; i < 28; i++) begin
            reg_bits[i*32 +: 32] = $urandom;
        end
        request       <= req_bits[$bits(request)-1:0];
        regs          <= reg_bits[$bits(regs)-1:0];
        request_valid <= ($urandom_range(0, 3) != 0);
    endtask

    initial begin
        int   cycles;
        int   taken;
        int   result_wait;
        logic flush_now;
        logic valid_exp;
        logic ready_exp;
        void'($urandom(32'h1b89ddc3));
        reset = 1'b1;
        flush = 1'b0;
        request = '0;
        request_valid = 1'b0;
        regs = '0;
        result_ready = 1'b0;
        cycles = 0;
        taken = 0;
        result_wait = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while (taken < num_results && cycles < max_cycles && result_wait < wait_limit) begin
            @(posedge clk);
            cycles++;
            result_wait++;
            // one queued entry stands for the single item the stage can hold
            valid_exp = (expected_q.size() != 0);
            ready_exp = !flush && (!valid_exp || result_ready);
            compare("result_valid", 128'(valid_exp), 128'(result_valid));
            compare("request_ready", 128'(ready_exp), 128'(request_ready));
            if (result_valid && result_ready) begin
                check_result(result);
                taken++;
                result_wait = 0;
            end
            // a flushed item never comes out
            if (flush) begin
                expected_q.delete();
            end
            if (request_valid && request_ready) begin
                expected_q.push_back(expected_result(request, regs));
            end
            if (expected_q.size() == 0) begin
                result_wait = 0;
            end
            if (!request_valid || request_ready) begin
                offer_request();
            end
            flush_now = ($urandom_range(0, 39) == 0);
            flush <= flush_now;
            result_ready <= !flush_now && ($urandom_range(0, 3) != 0);
        end
        if (taken == num_results) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("timeout: %0d of %0d results seen after %0d cycles",
                     taken, num_results, cycles);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/ag_arch_pkg.sv
common/ag_stage_pkg.sv
src/reg_size_selector.sv
operand/string_address_unit.sv
operand/operand_select.sv
src/pipe_stage.sv
src/address_generation_top.sv
tests/address_generation_properties.sv
tests/address_generation_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = address_generation_tb
FILELIST  = build.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --prefix V$(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
